/* project.f */
src/wb2sdrc_pkg.sv
src/sync_fifo.sv
src/wb_req_ctrl.sv
src/wb2sdrc_top.sv
verification/sdr_ctrl_model.sv
verification/tb_wb2sdrc.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator.
# The result is decided by the pass message in sim.log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f \
  --top-module tb_wb2sdrc -o sim_tb || exit 1

./obj_dir/sim_tb > sim.log 2>&1

grep -q "^NO ERRORS$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

/* src/sync_fifo.sv */
// Single-clock first-word-fall-through queue. The head entry is always on
// pop_data_o while empty_o is low; pop_i drops it at the next edge.
// Instantiated once per queue of the bridge with its own WIDTH and DEPTH.

`timescale 1ns/100ps

module sync_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 4
) (
  input  logic             wb_clk_i,
  input  logic             wb_rst_i,
  input  logic             push_i,
  input  logic [WIDTH-1:0] push_data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] pop_data_o,
  output logic             full_o,
  output logic             empty_o
);

  // Storage and bookkeeping, DEPTH of two or more
  logic [WIDTH-1:0]             mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]     wr_ptr;
  logic [$clog2(DEPTH)-1:0]     rd_ptr;
  logic [$clog2(DEPTH+1)-1:0]   count;
  logic                         do_push;
  logic                         do_pop;

  // Pointer step with wrap at DEPTH
  function automatic logic [$clog2(DEPTH)-1:0] next_ptr(
    input logic [$clog2(DEPTH)-1:0] ptr
  );
    logic [$clog2(DEPTH)-1:0] nxt;
    if (int'(ptr) == DEPTH - 1) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  // Qualified strobes
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // --------------------
  // Storage
  // --------------------

  always_ff @(posedge wb_clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  // Head shown straight from the array
  assign pop_data_o = mem[rd_ptr];

  // --------------------
  // Pointers and count
  // --------------------

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // Simultaneous push and pop leaves occupancy unchanged
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Status flags from occupancy
  assign full_o  = (int'(count) == DEPTH);
  assign empty_o = (count == '0);

  // Producer side must honour full
  a_no_overflow: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i) push_i |-> !full_o
  ) else $error("%m push while full");

  // Consumer side must honour empty
  a_no_underflow: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i) pop_i |-> !empty_o
  ) else $error("%m pop while empty");

endmodule

/* src/wb2sdrc_pkg.sv */
// Shared widths, queue depths and packed bundles for the Wishbone to SDRAM
// controller bridge. Modules import it inside their body and use scoped
// names in their port lists.

package wb2sdrc_pkg;

  // --------------------
  // Bus widths
  // --------------------

  // Wishbone and SDRAM data width
  localparam int DW  = 32;
  // Application address width
  localparam int AW  = 26;
  // Request length field width
  localparam int BLW = 9;
  // One select bit per byte
  localparam int SW  = DW / 8;

  // --------------------
  // Queue depths
  // --------------------

  // Commands waiting for the controller
  localparam int CMD_DEPTH = 4;
  // Write data with byte mask
  localparam int WR_DEPTH  = 8;
  // Read data coming back
  localparam int RD_DEPTH  = 4;

  // Every Wishbone transfer is a single beat
  localparam logic [BLW-1:0] REQ_LEN_SINGLE = BLW'(1);

  // --------------------
  // Packed bundles
  // --------------------

  // Command word towards the SDRAM controller
  typedef struct packed {
    logic [BLW-1:0] len;
    logic           wr_n;   // low for write, high for read
    logic [AW-1:0]  addr;
  } sdr_cmd_t;

  // Write beat, byte enables active low
  typedef struct packed {
    logic [SW-1:0] en_n;
    logic [DW-1:0] data;
  } sdr_wdat_t;

  // Read beat with end-of-burst marker
  typedef struct packed {
    logic          last;
    logic [DW-1:0] data;
  } sdr_rdat_t;

  // Wishbone request as seen by the slave
  typedef struct packed {
    logic          stb;
    logic          cyc;
    logic          we;
    logic [AW-1:0] addr;
    logic [DW-1:0] dat;
    logic [SW-1:0] sel;
  } wb_req_t;

endpackage

/* src/wb2sdrc_top.sv */
// Wishbone to SDRAM controller bridge, single clock. Joins the request
// control to the command, write-data and read-data queues and exposes the
// request/acknowledge handshake of the SDRAM controller.

`timescale 1ns/100ps

module wb2sdrc_top (
  input  logic                       wb_clk_i,
  input  logic                       wb_rst_i,
  // Wishbone slave
  input  logic                       wb_stb_i,
  input  logic                       wb_cyc_i,
  input  logic                       wb_we_i,
  input  logic [wb2sdrc_pkg::AW-1:0] wb_addr_i,
  input  logic [wb2sdrc_pkg::DW-1:0] wb_dat_i,
  input  logic [wb2sdrc_pkg::SW-1:0] wb_sel_i,
  output logic                       wb_ack_o,
  output logic [wb2sdrc_pkg::DW-1:0] wb_dat_o,
  // SDRAM controller handshake
  input  logic                       sdr_req_ack_i,
  input  logic                       sdr_wr_next_i,
  input  logic                       sdr_rd_valid_i,
  input  wb2sdrc_pkg::sdr_rdat_t     sdr_rdat_i,
  output logic                       sdr_req_o,
  output wb2sdrc_pkg::sdr_cmd_t      sdr_cmd_o,
  output wb2sdrc_pkg::sdr_wdat_t     sdr_wdat_o
);

  import wb2sdrc_pkg::*;

  // Bundled Wishbone request
  wb_req_t   wb_req;
  // Command queue
  logic      cmd_push;
  sdr_cmd_t  cmd_word;
  logic      cmd_full;
  logic      cmd_empty;
  // Write-data queue
  logic      wdat_push;
  sdr_wdat_t wdat_word;
  logic      wdat_full;
  // Read-data queue
  logic      rdat_pop;
  logic      rdat_empty;
  sdr_rdat_t rdat_head;

  // --------------------
  // Wishbone bundle
  // --------------------

  assign wb_req.stb  = wb_stb_i;
  assign wb_req.cyc  = wb_cyc_i;
  assign wb_req.we   = wb_we_i;
  assign wb_req.addr = wb_addr_i;
  assign wb_req.dat  = wb_dat_i;
  assign wb_req.sel  = wb_sel_i;

  // Ack, strobes and words for the queues
  wb_req_ctrl u_req_ctrl (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .wb_req_i     (wb_req),
    .cmd_full_i   (cmd_full),
    .wdat_full_i  (wdat_full),
    .rdat_empty_i (rdat_empty),
    .wb_ack_o     (wb_ack_o),
    .cmd_push_o   (cmd_push),
    .cmd_o        (cmd_word),
    .wdat_push_o  (wdat_push),
    .wdat_o       (wdat_word),
    .rdat_pop_o   (rdat_pop)
  );

  // --------------------
  // Queues
  // --------------------

  // Head leaves when the controller accepts the request
  sync_fifo #(.WIDTH($bits(sdr_cmd_t)), .DEPTH(CMD_DEPTH)) u_cmd_fifo (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .push_i      (cmd_push),
    .push_data_i (cmd_word),
    .pop_i       (sdr_req_ack_i),
    .pop_data_o  (sdr_cmd_o),
    .full_o      (cmd_full),
    .empty_o     (cmd_empty)
  );

  // Controller pulls beats with wr_next, emptiness implied by the command queue
  sync_fifo #(.WIDTH($bits(sdr_wdat_t)), .DEPTH(WR_DEPTH)) u_wdat_fifo (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .push_i      (wdat_push),
    .push_data_i (wdat_word),
    .pop_i       (sdr_wr_next_i),
    .pop_data_o  (sdr_wdat_o),
    .full_o      (wdat_full),
    .empty_o     ()
  );

  // One read in flight, so the single returned beat always fits
  sync_fifo #(.WIDTH($bits(sdr_rdat_t)), .DEPTH(RD_DEPTH)) u_rdat_fifo (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .push_i      (sdr_rd_valid_i),
    .push_data_i (sdr_rdat_i),
    .pop_i       (rdat_pop),
    .pop_data_o  (rdat_head),
    .full_o      (),
    .empty_o     (rdat_empty)
  );

  // Request stays up while any command waits
  assign sdr_req_o = !cmd_empty;
  // Read data valid together with the acknowledge
  assign wb_dat_o  = rdat_head.data;

endmodule

/* src/wb_req_ctrl.sv */
// Wishbone slave control for the SDRAM bridge. Generates the combinational
// acknowledge, tracks the single outstanding read and produces the push and
// pop strobes plus the command and write words for the queues in the top.

`timescale 1ns/100ps

module wb_req_ctrl (
  input  logic                   wb_clk_i,
  input  logic                   wb_rst_i,
  input  wb2sdrc_pkg::wb_req_t   wb_req_i,
  input  logic                   cmd_full_i,
  input  logic                   wdat_full_i,
  input  logic                   rdat_empty_i,
  output logic                   wb_ack_o,
  output logic                   cmd_push_o,
  output wb2sdrc_pkg::sdr_cmd_t  cmd_o,
  output logic                   wdat_push_o,
  output wb2sdrc_pkg::sdr_wdat_t wdat_o,
  output logic                   rdat_pop_o
);

  import wb2sdrc_pkg::*;

  // Decoded request phase
  logic wr_req;
  logic rd_req;
  // Room for a write beat in both queues
  logic wr_room;
  // Write and read acknowledges
  logic wr_ack;
  logic rd_ack;
  // Read command going into the command queue
  logic rd_cmd_push;
  // Read command issued, data not yet handed back
  logic pending_read;

  // --------------------
  // Request decode
  // --------------------

  // Valid cycle with direction
  assign wr_req = wb_req_i.stb && wb_req_i.cyc && wb_req_i.we;
  assign rd_req = wb_req_i.stb && wb_req_i.cyc && !wb_req_i.we;

  // Command and data go in together
  assign wr_room = !cmd_full_i && !wdat_full_i;

  // --------------------
  // Acknowledge
  // --------------------

  // Write completes as soon as it is queued
  assign wr_ack = wr_req && wr_room;
  // Read completes only once its data sits in the read queue
  assign rd_ack = rd_req && !rdat_empty_i;

  // One cycle per transfer, master drops stb afterwards
  assign wb_ack_o = wr_ack || rd_ack;

  // --------------------
  // Queue strobes
  // --------------------

  // Only the first cycle of a read issues its command
  assign rd_cmd_push = rd_req && !cmd_full_i && !pending_read;

  assign cmd_push_o  = wr_ack || rd_cmd_push;
  assign wdat_push_o = wr_ack;
  // Data leaves the read queue with the acknowledge
  assign rdat_pop_o  = rd_ack;

  // Command word, single beat every time
  assign cmd_o.len  = REQ_LEN_SINGLE;
  assign cmd_o.wr_n = !wb_req_i.we;
  assign cmd_o.addr = wb_req_i.addr;

  // Wishbone select is active high, SDRAM mask active low
  assign wdat_o.en_n = ~wb_req_i.sel;
  assign wdat_o.data = wb_req_i.dat;

  // --------------------
  // Pending read
  // --------------------

  // Set by the command push, cleared when the data is acknowledged
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      pending_read <= 1'b0;
    end else if (rd_cmd_push) begin
      pending_read <= 1'b1;
    end else if (rd_ack) begin
      pending_read <= 1'b0;
    end
  end

  // Read in flight always has its master still waiting on the bus
  a_read_held: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i) pending_read |-> rd_req
  ) else $error("%m read pending with no read request on the bus");

  // Read data must belong to a command issued in an earlier cycle
  a_read_matched: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i) rd_ack |-> pending_read
  ) else $error("%m read acknowledged without an issued command");

endmodule

/* verification/sdr_ctrl_model.sv */
// Behavioral SDRAM controller for the bridge testbench. Takes commands with
// a random acknowledge delay, applies writes to a small byte-maskable memory
// and returns read data a few cycles after the acknowledge.

`timescale 1ns/100ps

module sdr_ctrl_model (
  input  logic                   wb_clk_i,
  input  logic                   wb_rst_i,
  input  logic                   hold_i,
  input  logic                   sdr_req_i,
  input  wb2sdrc_pkg::sdr_cmd_t  sdr_cmd_i,
  input  wb2sdrc_pkg::sdr_wdat_t sdr_wdat_i,
  output logic                   sdr_req_ack_o,
  output logic                   sdr_wr_next_o,
  output logic                   sdr_rd_valid_o,
  output wb2sdrc_pkg::sdr_rdat_t sdr_rdat_o
);

  import wb2sdrc_pkg::*;

  // 64 words, indexed by the low address bits
  logic [DW-1:0] mem [64];

  // Inputs are read 1 ns after the falling edge, outputs change there too
  task automatic step();
    @(negedge wb_clk_i);
    #1;
  endtask

  initial begin
    sdr_cmd_t cmd;
    int       delay;
    sdr_req_ack_o  = 1'b0;
    sdr_wr_next_o  = 1'b0;
    sdr_rd_valid_o = 1'b0;
    sdr_rdat_o     = '0;
    // Fill pattern carries the word address
    for (int i = 0; i < 64; i++) begin
      mem[i] = 32'h5A5A_0000 | DW'(i);
    end
    forever begin
      step();
      if (!wb_rst_i && sdr_req_i && !hold_i) begin
        delay = int'($urandom_range(0, 7));
        repeat (delay) step();
        cmd           = sdr_cmd_i;
        sdr_req_ack_o = 1'b1;
        if (!cmd.wr_n) begin
          sdr_wr_next_o = 1'b1;
          // Byte enables are active low
          for (int b = 0; b < SW; b++) begin
            if (!sdr_wdat_i.en_n[b]) begin
              mem[cmd.addr[5:0]][8*b +: 8] = sdr_wdat_i.data[8*b +: 8];
            end
          end
        end
        step();
        sdr_req_ack_o = 1'b0;
        sdr_wr_next_o = 1'b0;
        if (cmd.wr_n) begin
          // Read beat 1 to 4 cycles after the acknowledge
          delay = int'($urandom_range(1, 4));
          repeat (delay - 1) step();
          sdr_rd_valid_o  = 1'b1;
          sdr_rdat_o.last = 1'b1;
          sdr_rdat_o.data = mem[cmd.addr[5:0]];
          step();
          sdr_rd_valid_o = 1'b0;
        end
      end
    end
  end

endmodule

/* verification/tb_wb2sdrc.sv */
// Testbench for the Wishbone to SDRAM bridge. Applies a table of single
// Wishbone transfers, checks read data against the table and a reference
// memory, and checks every command and write beat taken by the controller model.

`timescale 1ns/100ps

module tb_wb2sdrc;

  import wb2sdrc_pkg::*;

  // One Wishbone transfer per row
  typedef struct {
    string         name;
    bit            we;
    logic [AW-1:0] addr;
    logic [DW-1:0] data;
    logic [SW-1:0] sel;
    logic [DW-1:0] exp;
    bit            hold;
  } row_t;

  logic          wb_clk_i;
  logic          wb_rst_i;
  logic          wb_stb_i;
  logic          wb_cyc_i;
  logic          wb_we_i;
  logic [AW-1:0] wb_addr_i;
  logic [DW-1:0] wb_dat_i;
  logic [SW-1:0] wb_sel_i;
  logic          wb_ack_o;
  logic [DW-1:0] wb_dat_o;
  logic          sdr_req_ack;
  logic          sdr_wr_next;
  logic          sdr_rd_valid;
  sdr_rdat_t     sdr_rdat;
  logic          sdr_req;
  sdr_cmd_t      sdr_cmd;
  sdr_wdat_t     sdr_wdat;
  logic          hold;

  row_t          rows[$];
  sdr_cmd_t      exp_cmds[$];
  sdr_wdat_t     exp_wdats[$];
  logic [DW-1:0] ref_mem [64];
  int            cycles = 0;
  int            limit = 1000;
  int            n_valid = 0;
  int            n_rdack = 0;
  int            hold_acks = 0;

  wb2sdrc_top u_dut (
    .wb_clk_i       (wb_clk_i),
    .wb_rst_i       (wb_rst_i),
    .wb_stb_i       (wb_stb_i),
    .wb_cyc_i       (wb_cyc_i),
    .wb_we_i        (wb_we_i),
    .wb_addr_i      (wb_addr_i),
    .wb_dat_i       (wb_dat_i),
    .wb_sel_i       (wb_sel_i),
    .wb_ack_o       (wb_ack_o),
    .wb_dat_o       (wb_dat_o),
    .sdr_req_ack_i  (sdr_req_ack),
    .sdr_wr_next_i  (sdr_wr_next),
    .sdr_rd_valid_i (sdr_rd_valid),
    .sdr_rdat_i     (sdr_rdat),
    .sdr_req_o      (sdr_req),
    .sdr_cmd_o      (sdr_cmd),
    .sdr_wdat_o     (sdr_wdat)
  );

  sdr_ctrl_model u_sdr (
    .wb_clk_i       (wb_clk_i),
    .wb_rst_i       (wb_rst_i),
    .hold_i         (hold),
    .sdr_req_i      (sdr_req),
    .sdr_cmd_i      (sdr_cmd),
    .sdr_wdat_i     (sdr_wdat),
    .sdr_req_ack_o  (sdr_req_ack),
    .sdr_wr_next_o  (sdr_wr_next),
    .sdr_rd_valid_o (sdr_rd_valid),
    .sdr_rdat_o     (sdr_rdat)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #5 wb_clk_i = ~wb_clk_i;
  end

  // --------------------
  // Compare tasks
  // --------------------

  task automatic check_data(input string name, input logic [DW-1:0] exp,
                            input logic [DW-1:0] act);
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  task automatic check_cmd(input string name, input sdr_cmd_t exp, input sdr_cmd_t act);
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  task automatic check_wdat(input string name, input sdr_wdat_t exp, input sdr_wdat_t act);
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s expected %b actual %b", name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  task automatic add_row(input string name, input bit we, input logic [AW-1:0] addr,
                         input logic [DW-1:0] data, input logic [SW-1:0] sel,
                         input logic [DW-1:0] exp, input bit hold_en);
    row_t r;
    r.name = name;
    r.we   = we;
    r.addr = addr;
    r.data = data;
    r.sel  = sel;
    r.exp  = exp;
    r.hold = hold_en;
    rows.push_back(r);
  endtask

  // Drive at the falling edge, sample 1 ns before the rising edge
  task automatic apply_row(input row_t r);
    sdr_cmd_t  c;
    sdr_wdat_t w;
    if (r.hold) begin
      fork
        begin
          hold = 1'b1;
          repeat (12) @(negedge wb_clk_i);
          hold = 1'b0;
        end
      join_none
    end
    c.len  = REQ_LEN_SINGLE;
    c.wr_n = !r.we;
    c.addr = r.addr;
    exp_cmds.push_back(c);
    // Write beat carries the inverted select as its mask
    if (r.we) begin
      w.en_n = ~r.sel;
      w.data = r.data;
      exp_wdats.push_back(w);
    end
    wb_stb_i  = 1'b1;
    wb_cyc_i  = 1'b1;
    wb_we_i   = r.we;
    wb_addr_i = r.addr;
    wb_dat_i  = r.data;
    wb_sel_i  = r.sel;
    #4;
    while (!wb_ack_o) begin
      @(negedge wb_clk_i);
      #4;
    end
    if (r.we) begin
      if (hold) hold_acks++;
      for (int b = 0; b < SW; b++) begin
        if (r.sel[b]) ref_mem[r.addr[5:0]][8*b +: 8] = r.data[8*b +: 8];
      end
    end else begin
      check_data(r.name, r.exp, wb_dat_o);
      check_data({r.name, "_ref"}, ref_mem[r.addr[5:0]], wb_dat_o);
    end
    @(negedge wb_clk_i);
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
  endtask

  // --------------------
  // Monitors
  // --------------------

  always @(posedge wb_clk_i) begin
    cycles++;
    if (cycles >= limit) begin
      $display("Timeout after %0d cycles, a transfer never completed", cycles);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  end

  // Commands and write beats in order, reads never ahead of returned data
  always begin
    @(negedge wb_clk_i);
    #4;
    if (sdr_rd_valid) n_valid++;
    if (wb_ack_o && wb_stb_i && !wb_we_i) n_rdack++;
    if (n_rdack > n_valid) begin
      $display("Read acknowledged before the controller returned its data");
      $display("ERRORS FOUND");
      $fatal(1);
    end
    if (sdr_req_ack && sdr_req) begin
      if (exp_cmds.size() == 0) begin
        $display("Controller took a command that no transfer issued");
        $display("ERRORS FOUND");
        $fatal(1);
      end else begin
        check_cmd("cmd", exp_cmds.pop_front(), sdr_cmd);
      end
    end
    if (sdr_wr_next) begin
      if (exp_wdats.size() == 0) begin
        $display("Controller took a write beat that no transfer issued");
        $display("ERRORS FOUND");
        $fatal(1);
      end else begin
        check_wdat("wdat", exp_wdats.pop_front(), sdr_wdat);
      end
    end
  end

  initial begin
    void'($urandom(50374));
    wb_rst_i  = 1'b1;
    wb_stb_i  = 1'b0;
    wb_cyc_i  = 1'b0;
    wb_we_i   = 1'b0;
    wb_addr_i = '0;
    wb_dat_i  = '0;
    wb_sel_i  = '0;
    hold      = 1'b0;
    for (int i = 0; i < 64; i++) ref_mem[i] = 32'h5A5A_0000 | DW'(i);
    // Partial write 0101 keeps bytes 3 and 1
    add_row("wr_full", 1'b1, 26'd5, 32'h1122_3344, 4'hF, 32'h0, 1'b0);
    add_row("rd_full", 1'b0, 26'd5, 32'h0, 4'hF, 32'h1122_3344, 1'b0);
    add_row("wr_part", 1'b1, 26'd5, 32'hAABB_CCDD, 4'h5, 32'h0, 1'b0);
    add_row("rd_part", 1'b0, 26'd5, 32'h0, 4'hF, 32'h11BB_33DD, 1'b0);
    // Burst against a stalled controller
    add_row("wr_b0", 1'b1, 26'd10, 32'hB000_000A, 4'hF, 32'h0, 1'b1);
    add_row("wr_b1", 1'b1, 26'd11, 32'hB000_000B, 4'hF, 32'h0, 1'b0);
    add_row("wr_b2", 1'b1, 26'd12, 32'hB000_000C, 4'hF, 32'h0, 1'b0);
    add_row("wr_b3", 1'b1, 26'd13, 32'hB000_000D, 4'hF, 32'h0, 1'b0);
    add_row("wr_b4", 1'b1, 26'd14, 32'hB000_000E, 4'hF, 32'h0, 1'b0);
    add_row("wr_b5", 1'b1, 26'd15, 32'hB000_000F, 4'hF, 32'h0, 1'b0);
    add_row("rd_b0", 1'b0, 26'd10, 32'h0, 4'hF, 32'hB000_000A, 1'b0);
    add_row("rd_b5", 1'b0, 26'd15, 32'h0, 4'hF, 32'hB000_000F, 1'b0);
    add_row("rd_fill", 1'b0, 26'd20, 32'h0, 4'hF, 32'h5A5A_0014, 1'b0);
    limit = rows.size() * 20 + 100;
    repeat (5) @(negedge wb_clk_i);
    wb_rst_i = 1'b0;
    // Idle after reset
    repeat (5) begin
      @(negedge wb_clk_i);
      #4;
      check_flag("idle_ack", 1'b0, wb_ack_o);
      check_flag("idle_req", 1'b0, sdr_req);
    end
    @(negedge wb_clk_i);
    foreach (rows[i]) apply_row(rows[i]);
    // Four commands fit while the controller stalls
    check_data("hold_acks", 32'd4, DW'(hold_acks));
    $display("NO ERRORS");
    $finish;
  end

endmodule
